// ==== btb.sv ====
/*
 * Branch target buffer
 * Direct-mapped, banked entry array with two-slot lookup. Same-bank
 * write collisions are deferred through a small queue that drains into
 * idle write ports.
 */
`timescale 1ns/1ps
`default_nettype none

module btb import btbPkg::*; #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int bankNum = 2,
    parameter int queueSize = 4
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  PcPath                           predNextPc,
    input  BranchResult [issueWidth-1:0]    brResult,
    input  logic                            initBusy,
    input  BtbIndexPath                     initIndex,
    output BtbPrediction [fetchWidth-1:0]   prediction
);

    localparam int queuePtrWidth = $clog2(queueSize);

    // Entry array access
    logic [issueWidth-1:0]          wrEn;
    BtbIndexPath [issueWidth-1:0]   wrIndex;
    BtbEntry [issueWidth-1:0]       wrData;
    BtbIndexPath [fetchWidth-1:0]   rdIndex;
    BtbEntry [fetchWidth-1:0]       rdEntry;

    // Lookup stage
    PcPath [fetchWidth-1:0] slotPc;
    PcPath [fetchWidth-1:0] slotPcReg;
    logic lookupEnable;

    // Conflict queue
    logic pushQueue;
    logic popQueue;
    logic queueFull;
    logic queueEmpty;
    logic [queuePtrWidth-1:0] headPtr;
    logic [queuePtrWidth-1:0] tailPtr;
    BtbQueueEntry queueMem [queueSize];
    BtbQueueEntry queueIn;
    BtbQueueEntry queueHead;

    function automatic logic isSameBank(input BtbIndexPath a, input BtbIndexPath b);
        return (int'(a) % bankNum) == (int'(b) % bankNum);
    endfunction

    multiBankRam #(
        .entryNum(BTB_ENTRY_NUM),
        .entryWidth($bits(BtbEntry)),
        .readNum(fetchWidth),
        .writeNum(issueWidth),
        .bankNum(bankNum)
    ) i_entryArray (
        .clk(clk),
        .we(wrEn),
        .wa(wrIndex),
        .wv(wrData),
        .ra(rdIndex),
        .rv(rdEntry)
    );

    queuePointer #(
        .size(queueSize)
    ) i_queuePointer (
        .clk(clk),
        .rstN(rstN),
        .push(pushQueue),
        .pop(popQueue),
        .full(queueFull),
        .empty(queueEmpty),
        .headPtr(headPtr),
        .tailPtr(tailPtr)
    );

    // Slot PCs and read indices
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            slotPc[i] = predNextPc + PcPath'(i * INSN_BYTE_WIDTH);
            rdIndex[i] = toBtbIndex(slotPc[i]);
        end
    end

    always_ff @(posedge clk) begin
        slotPcReg <= slotPc;
    end

    // No hits until the array has been cleared
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lookupEnable <= 1'b0;
        end else begin
            lookupEnable <= !initBusy;
        end
    end

    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            prediction[i].hit = lookupEnable && rdEntry[i].valid &&
                                (rdEntry[i].tag == toBtbTag(slotPcReg[i]));
            prediction[i].target = toRawAddr(rdEntry[i].addr, slotPcReg[i]);
            prediction[i].isCondBr = rdEntry[i].isCondBr;
            prediction[i].isRasPushBr = rdEntry[i].isRasPushBr;
            prediction[i].isRasPopBr = rdEntry[i].isRasPopBr;
        end
    end

    // Queue storage
    always_ff @(posedge clk) begin
        if (pushQueue) begin
            queueMem[tailPtr] <= queueIn;
        end
    end

    assign queueHead = queueMem[headPtr];

    always_comb begin
        logic laneConflict;
        logic headBlocked;

        // Direct writes from the execution lanes
        for (int i = 0; i < issueWidth; i++) begin
            wrEn[i] = brResult[i].valid && brResult[i].taken;
            wrIndex[i] = toBtbIndex(brResult[i].brAddr);
            wrData[i].valid = 1'b1;
            wrData[i].tag = toBtbTag(brResult[i].brAddr);
            wrData[i].addr = toBtbAddr(brResult[i].targetAddr);
            wrData[i].isCondBr = brResult[i].isCondBr;
            wrData[i].isRasPushBr = brResult[i].isRasPushBr;
            wrData[i].isRasPopBr = brResult[i].isRasPopBr;
        end

        // Later lane loses a bank collision and goes to the queue
        pushQueue = 1'b0;
        queueIn = '0;
        for (int i = 1; i < issueWidth; i++) begin
            laneConflict = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (wrEn[j] && isSameBank(wrIndex[i], wrIndex[j])) begin
                    laneConflict = 1'b1;
                end
            end
            if (wrEn[i] && laneConflict) begin
                wrEn[i] = 1'b0;
                // Only one push per cycle; a full queue loses the write
                if (!pushQueue && !queueFull) begin
                    pushQueue = 1'b1;
                    queueIn.index = wrIndex[i];
                    queueIn.entry = wrData[i];
                end
            end
        end

        // Drain head into the first idle port if its bank is free
        popQueue = 1'b0;
        headBlocked = 1'b0;
        for (int j = 0; j < issueWidth; j++) begin
            if (wrEn[j] && isSameBank(queueHead.index, wrIndex[j])) begin
                headBlocked = 1'b1;
            end
        end
        for (int i = 0; i < issueWidth; i++) begin
            if (!queueEmpty && !headBlocked && !popQueue && !wrEn[i]) begin
                popQueue = 1'b1;
                wrEn[i] = 1'b1;
                wrIndex[i] = queueHead.index;
                wrData[i] = queueHead.entry;
            end
        end

        // Init clears one entry per cycle on port 0 only
        if (initBusy) begin
            for (int i = 0; i < issueWidth; i++) begin
                wrEn[i] = (i == 0);
                wrIndex[i] = initIndex;
                wrData[i] = '0;
            end
            pushQueue = 1'b0;
            popQueue = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== btbInitSequencer.sv ====
/*
 * BTB initialisation sequencer
 * After reset, steps through every entry index, one per cycle, with
 * initBusy high, then holds initBusy low until the next reset.
 */
`timescale 1ns/1ps
`default_nettype none

module btbInitSequencer import btbPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    output logic        initBusy,
    output BtbIndexPath initIndex
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            initBusy <= 1'b1;
            initIndex <= '0;
        end else if (initBusy) begin
            initIndex <= initIndex + 1'b1;
            // Last entry cleared this cycle
            if (initIndex == BtbIndexPath'(BTB_ENTRY_NUM - 1)) begin
                initBusy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== btbPkg.sv ====
/*
 * BTB shared types
 * PC and entry widths, the stored entry and update formats, and the
 * helpers that split a PC into index and tag and rebuild a target.
 */
`default_nettype none

package btbPkg;

    // Instruction byte address
    typedef logic [31:0] PcPath;

    localparam int INSN_BYTE_WIDTH = 4;
    localparam int BTB_ENTRY_NUM = 64;

    // Entry index from PC[7:2], tag from PC[17:8]
    typedef logic [5:0] BtbIndexPath;
    typedef logic [9:0] BtbTagPath;

    // Stored part of a target, target[17:2]
    typedef logic [15:0] BtbAddrPath;

    typedef struct packed {
        logic       valid;
        BtbTagPath  tag;
        BtbAddrPath addr;
        logic       isCondBr;
        logic       isRasPushBr;
        logic       isRasPopBr;
    } BtbEntry;

    // Resolved branch from one execution lane
    typedef struct packed {
        logic  valid;
        logic  taken;
        PcPath brAddr;
        PcPath targetAddr;
        logic  isCondBr;
        logic  isRasPushBr;
        logic  isRasPopBr;
    } BranchResult;

    typedef struct packed {
        logic  hit;
        PcPath target;
        logic  isCondBr;
        logic  isRasPushBr;
        logic  isRasPopBr;
    } BtbPrediction;

    // Deferred write waiting in the conflict queue
    typedef struct packed {
        BtbIndexPath index;
        BtbEntry     entry;
    } BtbQueueEntry;

    function automatic BtbIndexPath toBtbIndex(input PcPath addr);
        return addr[7:2];
    endfunction

    function automatic BtbTagPath toBtbTag(input PcPath addr);
        return addr[17:8];
    endfunction

    function automatic BtbAddrPath toBtbAddr(input PcPath addr);
        return addr[17:2];
    endfunction

    // Upper bits come from the slot PC that did the lookup
    function automatic PcPath toRawAddr(input BtbAddrPath addr, input PcPath pc);
        return {pc[31:18], addr, 2'b00};
    endfunction

endpackage

`default_nettype wire

// ==== btbTop.sv ====
/*
 * BTB top level
 * Joins the initialisation sequencer to the buffer and fixes the
 * fetch width, issue width, bank count and queue depth.
 */
`timescale 1ns/1ps
`default_nettype none

module btbTop import btbPkg::*; #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int bankNum = 2,
    parameter int queueSize = 4
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  PcPath                           predNextPc,
    input  BranchResult [issueWidth-1:0]    brResult,
    output BtbPrediction [fetchWidth-1:0]   prediction,
    output logic                            initBusy
);

    BtbIndexPath initIndex;

    btbInitSequencer i_initSequencer (
        .clk(clk),
        .rstN(rstN),
        .initBusy(initBusy),
        .initIndex(initIndex)
    );

    btb #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth),
        .bankNum(bankNum),
        .queueSize(queueSize)
    ) i_btb (
        .clk(clk),
        .rstN(rstN),
        .predNextPc(predNextPc),
        .brResult(brResult),
        .initBusy(initBusy),
        .initIndex(initIndex),
        .prediction(prediction)
    );

endmodule

`default_nettype wire

// ==== multiBankRam.sv ====
/*
 * Banked RAM with several write and registered read ports
 * Entries interleave over banks by the low index bits. Each bank takes
 * one write per cycle; read data returns one cycle after the index.
 */
`timescale 1ns/1ps
`default_nettype none

module multiBankRam #(
    parameter int entryNum = 64,
    parameter int entryWidth = 32,
    parameter int readNum = 2,
    parameter int writeNum = 2,
    parameter int bankNum = 2
) (
    input  logic                                         clk,
    input  logic [writeNum-1:0]                          we,
    input  logic [writeNum-1:0][$clog2(entryNum)-1:0]    wa,
    input  logic [writeNum-1:0][entryWidth-1:0]          wv,
    input  logic [readNum-1:0][$clog2(entryNum)-1:0]     ra,
    output logic [readNum-1:0][entryWidth-1:0]           rv
);

    localparam int rowNum = entryNum / bankNum;
    localparam int rowWidth = $clog2(rowNum);
    localparam int bankWidth = (bankNum > 1) ? $clog2(bankNum) : 1;

    // Bank each read lane addressed last cycle
    logic [readNum-1:0][bankWidth-1:0] readBank;
    logic [bankNum-1:0][readNum-1:0][entryWidth-1:0] bankRv;

    for (genvar b = 0; b < bankNum; b++) begin : gBank
        logic [entryWidth-1:0] mem [rowNum];
        logic                  bankWe;
        logic [rowWidth-1:0]   bankRow;
        logic [entryWidth-1:0] bankWv;
        logic [readNum-1:0][entryWidth-1:0] rdReg;

        // Lowest numbered port addressing this bank wins
        always_comb begin
            bankWe = 1'b0;
            bankRow = '0;
            bankWv = '0;
            for (int w = writeNum - 1; w >= 0; w--) begin
                if (we[w] && ((int'(wa[w]) % bankNum) == b)) begin
                    bankWe = 1'b1;
                    bankRow = rowWidth'(int'(wa[w]) / bankNum);
                    bankWv = wv[w];
                end
            end
        end

        always_ff @(posedge clk) begin
            if (bankWe) begin
                mem[bankRow] <= bankWv;
            end
            // Every lane reads this bank; the lane's bank select picks later
            for (int r = 0; r < readNum; r++) begin
                rdReg[r] <= mem[rowWidth'(int'(ra[r]) / bankNum)];
            end
        end

        assign bankRv[b] = rdReg;
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < readNum; r++) begin
            readBank[r] <= bankWidth'(int'(ra[r]) % bankNum);
        end
    end

    always_comb begin
        for (int r = 0; r < readNum; r++) begin
            rv[r] = bankRv[readBank[r]][r];
        end
    end

endmodule

`default_nettype wire

// ==== queuePointer.sv ====
/*
 * Circular queue pointers
 * Head and tail with wrap-around, plus an occupancy count for the
 * full and empty flags. Pushes into a full queue are dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module queuePointer #(
    parameter int size = 4
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    push,
    input  logic                    pop,
    output logic                    full,
    output logic                    empty,
    output logic [$clog2(size)-1:0] headPtr,
    output logic [$clog2(size)-1:0] tailPtr
);

    localparam int ptrWidth = $clog2(size);
    localparam int countWidth = $clog2(size + 1);

    logic [countWidth-1:0] count;
    logic doPush;
    logic doPop;

    assign doPush = push && !full;
    assign doPop = pop && !empty;

    assign full = (count == countWidth'(size));
    assign empty = (count == '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= (tailPtr == ptrWidth'(size - 1)) ? '0 : tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= (headPtr == ptrWidth'(size - 1)) ? '0 : headPtr + 1'b1;
            end
            // Count is unchanged when both happen
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tbBtb.sv ====
/*
 * BTB testbench
 * Directed tests against a 64-entry reference model covering init,
 * single writes, ignored results, bank conflicts and random updates.
 */
`timescale 1ns/1ps
`default_nettype none

module tbBtb import btbPkg::*; ();

    localparam int maxCycles = 2000;

    logic clk;
    logic rstN;
    PcPath predNextPc;
    BranchResult [1:0] brResult;
    BtbPrediction [1:0] prediction;
    logic initBusy;

    BtbEntry refModel [BTB_ENTRY_NUM];
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int seed = 32'h31a7_b961;

    btbTop i_btbTop (
        .clk(clk),
        .rstN(rstN),
        .predNextPc(predNextPc),
        .brResult(brResult),
        .prediction(prediction),
        .initBusy(initBusy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= maxCycles);
        $display("Timeout: run did not finish within %0d cycles", maxCycles);
        $display("Checks failed");
        $finish;
    end

    task automatic reportError(input string msg);
        errorCount++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    function automatic BranchResult makeResult(input PcPath brAddr, input PcPath target,
                                               input logic [2:0] kind, input logic valid,
                                               input logic taken);
        BranchResult r;
        r.valid = valid;
        r.taken = taken;
        r.brAddr = brAddr;
        r.targetAddr = target;
        {r.isCondBr, r.isRasPushBr, r.isRasPopBr} = kind;
        return r;
    endfunction

    // Reference update, valid and taken results only
    task automatic applyToModel(input BranchResult r);
        BtbEntry e;
        if (r.valid && r.taken) begin
            e.valid = 1'b1;
            e.tag = toBtbTag(r.brAddr);
            e.addr = toBtbAddr(r.targetAddr);
            {e.isCondBr, e.isRasPushBr, e.isRasPopBr} =
                {r.isCondBr, r.isRasPushBr, r.isRasPopBr};
            refModel[toBtbIndex(r.brAddr)] = e;
        end
    endtask

    task automatic checkSlot(input int slot, input PcPath slotPc);
        BtbEntry e;
        logic expHit;
        PcPath expTarget;
        e = refModel[toBtbIndex(slotPc)];
        expHit = e.valid && (e.tag == toBtbTag(slotPc));
        expTarget = toRawAddr(e.addr, slotPc);
        checkCount++;
        if (prediction[slot].hit !== expHit) begin
            reportError($sformatf("slot %0d pc %h hit %b, expected %b",
                                  slot, slotPc, prediction[slot].hit, expHit));
        end else if (expHit) begin
            if (prediction[slot].target !== expTarget) begin
                reportError($sformatf("slot %0d pc %h target %h, expected %h",
                                      slot, slotPc, prediction[slot].target, expTarget));
            end
            if ({prediction[slot].isCondBr, prediction[slot].isRasPushBr,
                 prediction[slot].isRasPopBr} !==
                {e.isCondBr, e.isRasPushBr, e.isRasPopBr}) begin
                reportError($sformatf("slot %0d pc %h kind flags wrong", slot, slotPc));
            end
        end
    endtask

    // Present a lookup and check both slots one cycle later
    task automatic lookupCheck(input PcPath pc);
        predNextPc = pc;
        brResult = '0;
        @(negedge clk);
        for (int i = 0; i < 2; i++) begin
            checkSlot(i, pc + PcPath'(i * INSN_BYTE_WIDTH));
        end
    endtask

    task automatic writeResults(input BranchResult r0, input BranchResult r1);
        brResult[0] = r0;
        brResult[1] = r1;
        applyToModel(r0);
        applyToModel(r1);
        @(negedge clk);
        brResult = '0;
    endtask

    task automatic idleCycles(input int n);
        brResult = '0;
        repeat (n) @(negedge clk);
    endtask

    // Four tags over sixteen indices, so overwrites are frequent
    task automatic randomResult(output BranchResult r);
        PcPath pc;
        PcPath target;
        pc = $random(seed);
        pc[17:10] = 8'h5a;
        pc[7:6] = 2'b00;
        pc[1:0] = 2'b00;
        target = $random(seed);
        r = makeResult(pc, target, 3'($random(seed)), 1'b1, 1'b1);
    endtask

    task automatic testInit();
        int busyCycles;
        int lateIndex;
        PcPath ignored[$];
        PcPath pc;
        busyCycles = 0;
        while (initBusy === 1'b1 && busyCycles < 100) begin
            busyCycles++;
            predNextPc = $random(seed);
            brResult = '0;
            // Late results aim at entries the clear has already passed
            if (busyCycles > BTB_ENTRY_NUM - 8) begin
                lateIndex = busyCycles - (BTB_ENTRY_NUM - 7);
                pc = $random(seed);
                pc[7:2] = BtbIndexPath'(lateIndex);
                pc[1:0] = 2'b00;
                ignored.push_back(pc);
                brResult[0] = makeResult(pc, pc + 32'h100, 3'b001, 1'b1, 1'b1);
                // Lane 1 shares the bank of lane 0
                pc = $random(seed);
                pc[7:2] = BtbIndexPath'(lateIndex + 8);
                pc[1:0] = 2'b00;
                ignored.push_back(pc);
                brResult[1] = makeResult(pc, pc + 32'h200, 3'b010, 1'b1, 1'b1);
            end
            @(negedge clk);
            if (prediction[0].hit !== 1'b0 || prediction[1].hit !== 1'b0) begin
                reportError("hit reported during initialisation");
            end
        end
        brResult = '0;
        checkCount++;
        if (busyCycles != BTB_ENTRY_NUM) begin
            reportError($sformatf("initBusy high for %0d cycles, expected %0d",
                                  busyCycles, BTB_ENTRY_NUM));
        end
        foreach (ignored[i]) begin
            lookupCheck(ignored[i]);
        end
    endtask

    task automatic testSingleWrite();
        PcPath pc;
        pc = 32'h0001_2340;
        writeResults(makeResult(pc, 32'habcd_5678, 3'b101, 1'b1, 1'b1), '0);
        lookupCheck(pc);
        lookupCheck(pc - 32'd4);
    endtask

    task automatic testIgnoredResults();
        writeResults(makeResult(32'h0002_0080, 32'h0000_1000, 3'b100, 1'b1, 1'b0),
                     makeResult(32'h0002_0090, 32'h0000_2000, 3'b010, 1'b0, 1'b1));
        lookupCheck(32'h0002_0080);
        lookupCheck(32'h0002_0090);
        // Same index as the single write, other tag
        lookupCheck(32'h0001_2340 ^ 32'h0000_0100);
    endtask

    task automatic testBankConflict();
        // Indices 10 and 12 share bank 0
        writeResults(makeResult(32'h0000_1028, 32'h0000_4444, 3'b100, 1'b1, 1'b1),
                     makeResult(32'h0000_2030, 32'h0000_8888, 3'b010, 1'b1, 1'b1));
        idleCycles(4);
        lookupCheck(32'h0000_1028);
        lookupCheck(32'h0000_2030);
        // Indices 20 and 21 sit in different banks, seen by one lookup
        writeResults(makeResult(32'h0004_5150, 32'h0001_0000, 3'b001, 1'b1, 1'b1),
                     makeResult(32'h0004_5154, 32'h0002_0000, 3'b110, 1'b1, 1'b1));
        lookupCheck(32'h0004_5150);
    endtask

    task automatic testRandom();
        int written;
        BranchResult r0;
        BranchResult r1;
        PcPath addrs[$];
        written = 0;
        while (written < 60) begin
            randomResult(r0);
            addrs.push_back(r0.brAddr);
            r1 = '0;
            if (written < 59 && ($random(seed) & 1)) begin
                randomResult(r1);
                addrs.push_back(r1.brAddr);
            end
            writeResults(r0, r1);
            written += r1.valid ? 2 : 1;
            idleCycles(2);
        end
        foreach (addrs[i]) begin
            lookupCheck(addrs[i]);
        end
    endtask

    initial begin
        rstN = 1'b0;
        predNextPc = '0;
        brResult = '0;
        for (int i = 0; i < BTB_ENTRY_NUM; i++) begin
            refModel[i] = '0;
        end
        repeat (3) @(negedge clk);
        rstN = 1'b1;

        testInit();
        testSingleWrite();
        testIgnoredResults();
        testBankConflict();
        testRandom();

        checkCount++;
        if (initBusy !== 1'b0) begin
            reportError("initBusy rose again after initialisation");
        end

        $display("Summary: %0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
btbPkg.sv
multiBankRam.sv
queuePointer.sv
btbInitSequencer.sv
btb.sv
btbTop.sv
tbBtb.sv
